/* sim.f */
source/prf_pkg.sv
source/prf_wr_if.sv
source/prf_ram.sv
source/prf_write_queue.sv
source/prf_regfile.sv
source/prf_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_prf.sv

/* source/prf_pkg.sv */
`default_nettype none

package prf_pkg;

   // ============================================================
   // Register file geometry
   // ============================================================
   localparam int PREGS      = 64;                  // Physical registers
   localparam int VALUE_W    = 32;                  // Bits per register
   localparam int BYTE_LANES = 4;                   // Write lanes per register
   localparam int LANE_W     = VALUE_W / BYTE_LANES; // Bits per lane
   localparam int NRD        = 2;                   // Read ports, one RAM copy each

   // Write queue, depth doubles as the producer credit count
   localparam int WQ_DEPTH   = 4;

   // Derived widths
   localparam int PREG_W     = $clog2(PREGS);
   localparam int WQ_PTR_W   = $clog2(WQ_DEPTH);      // Power of two depth, pointers wrap
   localparam int WQ_CNT_W   = $clog2(WQ_DEPTH + 1);  // Count has to reach WQ_DEPTH

   // ============================================================
   // Types
   // ============================================================
   typedef logic [VALUE_W-1:0]    value_t;   // One register value
   typedef logic [PREG_W-1:0]     preg_t;    // Physical register tag
   typedef logic [BYTE_LANES-1:0] wbe_t;     // Byte write mask
   typedef logic [WQ_CNT_W-1:0]   wq_cnt_t;  // Queue occupancy
   typedef logic [WQ_PTR_W-1:0]   wq_ptr_t;  // Queue slot index

endpackage

`default_nettype wire

/* source/prf_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_ram
   import prf_pkg::*;
(
   input  logic   clka,
   input  logic   reset,
   input  logic   we,      // Commit strobe
   input  wbe_t   wbe,     // Lanes written on this commit
   input  preg_t  waddr,   // Commit tag
   input  value_t wdata,
   input  logic   re,      // Read enable
   input  preg_t  raddr,
   output value_t rdata    // Registered, holds while re is low
);

   // Array comes up all zero
   value_t mem [PREGS] = '{default: '0};

   // ============================================================
   // Write port
   // ============================================================
   always_ff @(posedge clka) begin
      if (we) begin
         for (int l = 0; l < BYTE_LANES; l++) begin
            if (wbe[l])                                                // Lane enabled
               mem[waddr][l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
         end
      end
   end

   // ============================================================
   // Read port
   // ============================================================
   // Same edge write to raddr is not seen here, old value comes out
   // The register file bypass supplies the new lanes
   always_ff @(posedge clka) begin
      if (reset)
         rdata <= '0;
      else if (re)
         rdata <= mem[raddr];
   end

   // A commit from the queue always carries at least one lane
   a_we_has_lanes : assert property (
      @(posedge clka) disable iff (reset)
      we |-> (wbe != '0))
      else $error("prf_ram: write strobe with empty byte mask at %0t", $time);

endmodule

`default_nettype wire

/* source/prf_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_regfile
   import prf_pkg::*;
(
   input  logic   clka,
   input  logic   reset,
   prf_wr_if.dst  wq,                 // Commits from the write queue
   input  logic   rd_en   [NRD],
   input  preg_t  rd_addr [NRD],
   output value_t rd_data [NRD]       // Two edges after rd_en is sampled
);

   // Byte mask spread to a bit mask
   function automatic value_t lane_mask(input wbe_t be);
      value_t m;
      for (int l = 0; l < BYTE_LANES; l++)
         m[l*LANE_W +: LANE_W] = {LANE_W{be[l]}};
      return m;
   endfunction

   value_t wq_mask;   // Bits touched by the current commit

   assign wq_mask = lane_mask(wq.be);

   // ============================================================
   // One RAM copy and bypass per read port
   // ============================================================
   for (genvar p = 0; p < NRD; p++) begin : g_port
      value_t ram_q;      // Read-first RAM output
      logic   hit;        // Commit to the address being read
      logic   byp_hit;    // Registered beside ram_q
      value_t byp_mask;
      value_t byp_data;   // New lanes, others zero
      logic   rd_vld;     // ram_q and bypass hold a fresh read
      value_t merged;

      prf_ram u_ram (
         .clka  (clka),
         .reset (reset),
         .we    (wq.valid),   // All copies see every commit
         .wbe   (wq.be),
         .waddr (wq.tag),
         .wdata (wq.data),
         .re    (rd_en[p]),
         .raddr (rd_addr[p]),
         .rdata (ram_q)
      );

      assign hit = wq.valid && (wq.tag == rd_addr[p]);

      always_ff @(posedge clka) begin
         if (reset)
            byp_hit <= 1'b0;
         else if (rd_en[p])
            byp_hit <= hit;                               // Track the read, hold otherwise
      end

      always_ff @(posedge clka) begin
         if (rd_en[p] && hit) begin
            byp_mask <= wq_mask;
            byp_data <= wq.data & wq_mask;
         end
      end

      // Write-first result, disabled lanes keep the RAM value
      assign merged = byp_hit ? ((ram_q & ~byp_mask) | byp_data) : ram_q;

      // Output register
      always_ff @(posedge clka) begin
         if (reset) begin
            rd_vld     <= 1'b0;
            rd_data[p] <= '0;
         end else begin
            rd_vld <= rd_en[p];
            if (rd_vld)
               rd_data[p] <= merged;                      // Holds while no read
         end
      end
   end

endmodule

`default_nettype wire

/* source/prf_top.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_top
   import prf_pkg::*;
(
   input  logic   clka,
   input  logic   reset,

   // Write-back port, credit based
   input  logic   wr_valid,
   input  preg_t  wr_tag,
   input  wbe_t   wr_be,
   input  value_t wr_data,
   output logic   wr_credit,

   // Read ports
   input  logic   rd_en   [NRD],
   input  preg_t  rd_addr [NRD],
   output value_t rd_data [NRD]
);

   // Commit bus between queue and register file
   prf_wr_if wq ();

   // ============================================================
   // Write queue
   // ============================================================
   prf_write_queue u_wq (
      .clka      (clka),
      .reset     (reset),
      .wr_valid  (wr_valid),
      .wr_tag    (wr_tag),
      .wr_be     (wr_be),
      .wr_data   (wr_data),
      .wr_credit (wr_credit),
      .wq        (wq.src)
   );

   // ============================================================
   // Register file
   // ============================================================
   prf_regfile u_rf (
      .clka    (clka),
      .reset   (reset),
      .wq      (wq.dst),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

/* source/prf_wr_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One committed register write, queue head to register file
interface prf_wr_if
   import prf_pkg::*;
();

   logic   valid;   // Commit in this cycle
   preg_t  tag;     // Destination physical register
   wbe_t   be;      // Lanes to update
   value_t data;    // New value, only enabled lanes matter

   // Queue side
   modport src (output valid, tag, be, data);

   // Register file side, always ready
   modport dst (input valid, tag, be, data);

endinterface

`default_nettype wire

/* source/prf_write_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_write_queue
   import prf_pkg::*;
(
   input  logic   clka,
   input  logic   reset,
   input  logic   wr_valid,   // Write-back from a credit holder
   input  preg_t  wr_tag,
   input  wbe_t   wr_be,
   input  value_t wr_data,
   output logic   wr_credit,  // One pulse per committed entry
   prf_wr_if.src  wq          // Commit bus to the register file
);

   // Entry storage
   preg_t   q_tag  [WQ_DEPTH];
   wbe_t    q_be   [WQ_DEPTH];
   value_t  q_data [WQ_DEPTH];

   wq_ptr_t head;     // Oldest entry
   wq_ptr_t tail;     // Next free slot
   wq_cnt_t cnt;      // Entries held

   logic    push;
   logic    pop;

   assign push = wr_valid;
   assign pop  = (cnt != '0);   // Register file takes a commit every cycle

   // ============================================================
   // Head entry onto the commit bus
   // ============================================================
   assign wq.valid = pop;
   assign wq.tag   = q_tag[head];
   assign wq.be    = q_be[head];
   assign wq.data  = q_data[head];

   // Payload slots
   always_ff @(posedge clka) begin
      if (push) begin
         q_tag[tail]  <= wr_tag;
         q_be[tail]   <= wr_be;
         q_data[tail] <= wr_data;
      end
   end

   // ============================================================
   // Pointers, occupancy and credit return
   // ============================================================
   always_ff @(posedge clka) begin
      if (reset) begin
         head      <= '0;
         tail      <= '0;
         cnt       <= '0;
         wr_credit <= 1'b0;
      end else begin
         wr_credit <= pop;                                // Credit in the cycle after commit
         if (push)
            tail <= tail + wq_ptr_t'(1);                  // Wraps at WQ_DEPTH
         if (pop)
            head <= head + wq_ptr_t'(1);
         case ({push, pop})
            2'b10:   cnt <= cnt + wq_cnt_t'(1);           // Fill only
            2'b01:   cnt <= cnt - wq_cnt_t'(1);           // Drain only
            default: cnt <= cnt;                          // Both or neither
         endcase
      end
   end

   // Producer must not send without a credit
   a_no_overflow : assert property (
      @(posedge clka) disable iff (reset)
      wr_valid |-> (cnt != wq_cnt_t'(WQ_DEPTH)))
      else $error("prf_write_queue: write-back into full queue at %0t", $time);

endmodule

`default_nettype wire

/* tb/prf_trace.txt */
# W tag be data | R port addr expected | D wait for all credits, fields in hex
# Consecutive R lines on different ports issue in the same cycle
R 0 00 00000000
R 1 3f 00000000
R 0 15 00000000
W 01 f 11111111
W 02 f 22222222
W 03 f 33333333
D
R 0 01 11111111
R 1 02 22222222
R 1 03 33333333
W 02 3 0000abcd
W 03 c 12340000
W 01 5 00ee00ee
W 3f f cafef00d
W 3e 8 99000000
W 3d 1 00000077
D
R 0 02 2222abcd
R 1 03 12343333
R 0 01 11ee11ee
R 1 3f cafef00d
R 0 3e 99000000
R 1 3d 00000077
W 10 f aaaa5555
R 0 10 aaaa5555
W 10 2 0000bb00
R 1 10 aaaabb55
W 20 f 01010101
R 0 20 01010101
W 20 f 02020202
D
R 1 20 02020202
R 0 10 aaaabb55
R 1 30 00000000

/* tb/tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_checker
   import prf_pkg::*;
(
   input  logic   clka,
   input  logic   reset,
   input  logic   wr_valid,
   input  logic   wr_credit,
   input  logic   rd_en   [NRD],
   input  value_t rd_data [NRD],
   input  logic   chk_en  [NRD],    // Read carries an expected value
   input  value_t chk_exp [NRD],
   output int     n_checked,
   output int     n_data_err,
   output int     n_proto_err,
   output int     n_sent,           // Writes seen on the port
   output int     n_returned,       // Credit pulses seen
   output logic   busy              // Reads still in flight
);

   // Expected values follow the read through the DUT pipeline
   logic   pend1 [NRD];   // Read sampled at the last edge
   logic   pend2 [NRD];   // rd_data updated at the last edge
   value_t exp1  [NRD];
   value_t exp2  [NRD];

   // ============================================================
   // Write port accounting and read tracking
   // ============================================================
   always @(posedge clka) begin
      if (reset) begin
         n_sent      <= 0;
         n_returned  <= 0;
         n_proto_err <= 0;
         for (int p = 0; p < NRD; p++) begin
            pend1[p] <= 1'b0;
            pend2[p] <= 1'b0;
         end
      end else begin
         if (wr_valid)
            n_sent <= n_sent + 1;
         if (wr_credit) begin
            if (n_returned >= n_sent) begin   // Nothing outstanding
               $display("Credit returned at time %0t with no write outstanding", $time);
               n_proto_err <= n_proto_err + 1;
            end
            n_returned <= n_returned + 1;
         end
         for (int p = 0; p < NRD; p++) begin
            pend2[p] <= pend1[p];
            exp2[p]  <= exp1[p];
            pend1[p] <= rd_en[p] && chk_en[p];
            exp1[p]  <= chk_exp[p];
         end
      end
   end

   // ============================================================
   // Compare in the middle of the cycle, rd_data is settled
   // ============================================================
   always @(negedge clka) begin
      if (reset) begin
         n_checked  = 0;
         n_data_err = 0;
      end else begin
         for (int p = 0; p < NRD; p++) begin
            if (pend2[p]) begin
               n_checked = n_checked + 1;
               if (rd_data[p] !== exp2[p]) begin
                  $display("[FAIL] time %0t rd_data[%0d] expected %08h actual %08h",
                           $time, p, exp2[p], rd_data[p]);
                  n_data_err = n_data_err + 1;
               end
            end
         end
      end
   end

   always_comb begin
      busy = 1'b0;
      for (int p = 0; p < NRD; p++)
         busy = busy | pend1[p] | pend2[p];
   end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
   output logic clka,
   output logic reset
);

   localparam int HALF_PERIOD  = 10;   // 20 ns clock
   localparam int RESET_CYCLES = 10;

   initial begin
      clka = 1'b0;
      forever #(HALF_PERIOD) clka = ~clka;
   end

   // Release just after an edge, like every other input
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clka);
      #1 reset = 1'b0;
   end

endmodule

`default_nettype wire

/* tb/tb_prf.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_prf
   import prf_pkg::*;
();

   localparam string TRACE_FILE = "tb/prf_trace.txt";
   localparam int    WAIT_LIMIT = 200;   // Cycles per wait

   logic   clka;
   logic   reset;
   logic   wr_valid;
   preg_t  wr_tag;
   wbe_t   wr_be;
   value_t wr_data;
   logic   wr_credit;
   logic   rd_en   [NRD];
   preg_t  rd_addr [NRD];
   value_t rd_data [NRD];
   logic   chk_en  [NRD];
   value_t chk_exp [NRD];

   int     n_checked;
   int     n_data_err;
   int     n_proto_err;
   int     n_sent;
   int     n_returned;
   logic   chk_busy;

   int     sent;          // Producer side credit bookkeeping
   int     returned;
   int     reads;         // Reads with an expected value
   int     timeouts;
   int     trace_errs;
   int     credit_errs;
   int     fd;
   string  line;

   tb_clock u_clk (.clka(clka), .reset(reset));

   prf_top DUT (
      .clka      (clka),
      .reset     (reset),
      .wr_valid  (wr_valid),
      .wr_tag    (wr_tag),
      .wr_be     (wr_be),
      .wr_data   (wr_data),
      .wr_credit (wr_credit),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   tb_checker u_chk (
      .clka        (clka),
      .reset       (reset),
      .wr_valid    (wr_valid),
      .wr_credit   (wr_credit),
      .rd_en       (rd_en),
      .rd_data     (rd_data),
      .chk_en      (chk_en),
      .chk_exp     (chk_exp),
      .n_checked   (n_checked),
      .n_data_err  (n_data_err),
      .n_proto_err (n_proto_err),
      .n_sent      (n_sent),
      .n_returned  (n_returned),
      .busy        (chk_busy)
   );

   // Each pulse gives one credit back to the producer
   always @(posedge clka) begin
      if (reset)
         returned <= 0;
      else if (wr_credit)
         returned <= returned + 1;
   end

   // ============================================================
   // Bounded waits
   // ============================================================
   task automatic wait_reset();
      int n = 0;
      do begin
         @(posedge clka);
         n++;
      end while (reset && n < WAIT_LIMIT);
      if (reset) begin
         $display("Reset was never released");
         timeouts++;
      end
      #1;
   endtask

   task automatic wait_credit();
      int n = 0;
      while ((WQ_DEPTH - sent + returned) == 0 && n < WAIT_LIMIT) begin
         @(posedge clka);
         #1;
         n++;
      end
      if ((WQ_DEPTH - sent + returned) == 0) begin
         $display("Timeout at time %0t waiting for a write credit", $time);
         timeouts++;
      end
   endtask

   // All queued writes committed once every credit is back
   task automatic wait_drain();
      int n = 0;
      while (returned != sent && n < WAIT_LIMIT) begin
         @(posedge clka);
         #1;
         n++;
      end
      if (returned != sent) begin
         $display("Timeout at time %0t, %0d credits never came back", $time, sent - returned);
         timeouts++;
      end
   endtask

   task automatic wait_checks();
      int n = 0;
      while (chk_busy && n < WAIT_LIMIT) begin
         @(posedge clka);
         #1;
         n++;
      end
      if (chk_busy) begin
         $display("Timeout at time %0t waiting for read results", $time);
         timeouts++;
      end
   endtask

   // ============================================================
   // Stimulus
   // ============================================================
   task automatic send_write(input preg_t tag, input wbe_t be, input value_t data);
      wait_credit();
      if (timeouts == 0) begin
         wr_valid = 1'b1;
         wr_tag   = tag;
         wr_be    = be;
         wr_data  = data;
         sent++;                 // Credit spent in this cycle
         @(posedge clka);
         #1;
         wr_valid = 1'b0;
      end
   endtask

   // Pending reads on all ports go out in one cycle
   task automatic issue_reads();
      logic any;
      any = 1'b0;
      for (int p = 0; p < NRD; p++)
         any = any | rd_en[p];
      if (any) begin
         @(posedge clka);
         #1;
         for (int p = 0; p < NRD; p++) begin
            rd_en[p]  = 1'b0;
            chk_en[p] = 1'b0;
         end
      end
   endtask

   task automatic run_line(input string text);
      int  a;
      int  b;
      int  c;
      int  n;
      byte cmd;
      cmd = (text.len() > 0) ? text.getc(0) : "#";
      if (cmd == "W" || cmd == "D")
         issue_reads();
      case (cmd)
         "W": begin
            n = $sscanf(text, "W %h %h %h", a, b, c);
            if (n == 3)
               send_write(preg_t'(a), wbe_t'(b), value_t'(c));
            else begin
               $display("Unreadable trace line: %s", text);
               trace_errs++;
            end
         end
         "R": begin
            n = $sscanf(text, "R %d %h %h", a, b, c);
            if (n == 3 && a >= 0 && a < NRD) begin
               if (rd_en[a])
                  issue_reads();          // Same port goes again next cycle
               rd_en[a]   = 1'b1;
               rd_addr[a] = preg_t'(b);
               chk_en[a]  = 1'b1;
               chk_exp[a] = value_t'(c);
               reads++;
            end else begin
               $display("Unreadable trace line: %s", text);
               trace_errs++;
            end
         end
         "D":            wait_drain();
         "#", "\n", "\r": ;              // Comment or blank
         default: begin
            $display("Unknown trace command: %s", text);
            trace_errs++;
         end
      endcase
   endtask

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      wr_valid = 1'b0;
      wr_tag   = '0;
      wr_be    = '0;
      wr_data  = '0;
      for (int p = 0; p < NRD; p++) begin
         rd_en[p]   = 1'b0;
         rd_addr[p] = '0;
         chk_en[p]  = 1'b0;
         chk_exp[p] = '0;
      end
      sent        = 0;
      reads       = 0;
      timeouts    = 0;
      trace_errs  = 0;
      credit_errs = 0;

      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open trace file %s", TRACE_FILE);
         trace_errs++;
      end else begin
         wait_reset();
         while (!$feof(fd) && timeouts == 0) begin
            if ($fgets(line, fd) != 0)
               run_line(line);
         end
         $fclose(fd);
         issue_reads();
         wait_drain();
         wait_checks();
         if (n_returned != n_sent) begin   // One credit per write
            $display("Lost credits, %0d writes sent and %0d credits returned",
                     n_sent, n_returned);
            credit_errs++;
         end
         if (n_checked != reads) begin
            $display("Only %0d of %0d reads were compared", n_checked, reads);
            credit_errs++;
         end
      end

      $write("Summary: %0d reads checked, %0d data errors, ", n_checked, n_data_err);
      $write("%0d protocol errors, %0d credit errors, ", n_proto_err, credit_errs);
      $display("%0d timeouts, %0d trace errors", timeouts, trace_errs);
      if (n_data_err == 0 && n_proto_err == 0 && credit_errs == 0 &&
          timeouts == 0 && trace_errs == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire
